/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module th_tb -o th_sim \
  && ./obj_dir/th_sim \
  || { echo "simulation did not pass"; exit 1; }

exit 0

/* source/th_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_checker (
  input  wire                        wb_clk_i,
  input  wire                        wb_rst_i,
  input  wire                        run_i,
  input  wire  th_pkg::th_addr_t     base_i,
  input  wire  [`TH_ADDR_W:0]        len_i,
  input  wire  th_pkg::th_word_t     seed_i,
  input  wire                        gen_done_i,
  input  wire                        gen_busy_i,
  input  wire  th_pkg::th_word_t     mem_rdata_i,
  input  wire  th_pkg::th_stat_sel_e status_sel_i,
  output th_pkg::th_addr_t           mem_raddr_o,
  output th_pkg::th_word_t           status_o
);

  logic                run_q;
  logic                rd_active_q;
  logic [`TH_ADDR_W:0] remain_q;
  th_pkg::th_addr_t    raddr_q;
  logic                cmp_valid_q;
  logic                cmp_last_q;
  th_pkg::th_addr_t    cmp_addr_q;
  logic                done_q;
  th_pkg::th_count_t   err_cnt_q;
  th_pkg::th_count_t   checked_q;
  th_pkg::th_addr_t    first_fail_q;
  logic                mismatch;
  logic                busy;
  logic                pass;

  assign mismatch = mem_rdata_i != th_pkg::th_pattern(cmp_addr_q, seed_i);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      run_q        <= 1'b0;
      rd_active_q  <= 1'b0;
      remain_q     <= '0;
      cmp_valid_q  <= 1'b0;
      cmp_last_q   <= 1'b0;
      done_q       <= 1'b0;
      err_cnt_q    <= '0;
      checked_q    <= '0;
      first_fail_q <= '0;
    end else begin
      run_q       <= run_i;
      cmp_valid_q <= rd_active_q;
      cmp_last_q  <= rd_active_q && (remain_q == '0);
      if (run_i && !run_q) begin
        rd_active_q  <= 1'b0;  // A new run drops the old results.
        done_q       <= 1'b0;
        err_cnt_q    <= '0;
        checked_q    <= '0;
        first_fail_q <= '0;
      end else begin
        if (gen_done_i) begin
          if (len_i == '0) begin
            done_q <= 1'b1;
          end else begin
            rd_active_q <= 1'b1;
          end
          remain_q <= len_i - 1'b1;
        end else if (rd_active_q) begin
          if (remain_q == '0) begin
            rd_active_q <= 1'b0;
          end else begin
            remain_q <= remain_q - 1'b1;
          end
        end
        if (cmp_valid_q) begin
          checked_q <= checked_q + 1'b1;
          if (mismatch) begin
            err_cnt_q <= err_cnt_q + 1'b1;
            if (err_cnt_q == '0) begin
              first_fail_q <= cmp_addr_q;
            end
          end
          if (cmp_last_q) begin
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // Read address pipe, one step ahead of the compare stage.
  always_ff @(posedge wb_clk_i) begin
    if (gen_done_i) begin
      raddr_q <= base_i;
    end else if (rd_active_q) begin
      raddr_q <= raddr_q + 1'b1;
    end
    cmp_addr_q <= raddr_q;
  end

  assign mem_raddr_o = raddr_q;

  assign busy = gen_busy_i | rd_active_q | cmp_valid_q;
  assign pass = done_q && (err_cnt_q == '0);

  always_comb begin
    case (status_sel_i)
      th_pkg::STAT_FLAGS:      status_o = {13'd0, busy, done_q, pass};
      th_pkg::STAT_ERRORS:     status_o = err_cnt_q;
      th_pkg::STAT_FIRST_FAIL: status_o = th_pkg::th_word_t'(first_fail_q);
      default:                 status_o = checked_q;
    endcase
  end

endmodule

`default_nettype wire

/* source/th_config.svh */
`ifndef TH_CONFIG_SVH
`define TH_CONFIG_SVH

// Data path widths and test memory size.
`define TH_DATA_W     16
`define TH_ADDR_W     8
`define TH_MEM_DEPTH  256

// Control registers, as word addresses taken from wb_adr_i[21:1].
`define TH_REG_CTRL_0 21'd0
`define TH_REG_CTRL_1 21'd1
`define TH_REG_CTRL_2 21'd2
`define TH_REG_CTRL_3 21'd3
`define TH_REG_CTRL_4 21'd4

// Status words start here and repeat every four words above it.
`define TH_STAT_BASE  21'd8

`endif

/* source/th_pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_pattern_gen (
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire                    run_i,
  input  wire                    inject_i,
  input  wire  th_pkg::th_addr_t base_i,
  input  wire  [`TH_ADDR_W:0]    len_i,
  input  wire  th_pkg::th_word_t seed_i,
  input  wire  th_pkg::th_addr_t inject_addr_i,
  output logic                   mem_we_o,
  output th_pkg::th_addr_t       mem_waddr_o,
  output th_pkg::th_word_t       mem_wdata_o,
  output logic                   gen_done_o,
  output logic                   busy_o
);

  logic                  run_q;
  logic                  run_rise;
  logic                  we_q;
  logic                  done_q;
  logic [`TH_ADDR_W:0]   remain_q;
  th_pkg::th_addr_t      waddr_q;
  logic                  flip;

  assign run_rise = run_i & ~run_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      run_q    <= 1'b0;
      we_q     <= 1'b0;
      done_q   <= 1'b0;
      remain_q <= '0;
    end else begin
      run_q  <= run_i;
      done_q <= 1'b0;
      if (run_rise) begin
        if (len_i == '0) begin
          done_q <= 1'b1;  // Nothing to write, finish at once.
        end else begin
          we_q <= 1'b1;
        end
        remain_q <= len_i - 1'b1;
      end else if (we_q) begin
        if (remain_q == '0) begin
          we_q   <= 1'b0;
          done_q <= 1'b1;
        end else begin
          remain_q <= remain_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (run_rise) begin
      waddr_q <= base_i;
    end else if (we_q) begin
      waddr_q <= waddr_q + 1'b1;  // Wraps at the top of memory.
    end
  end

  assign flip = inject_i && (waddr_q == inject_addr_i);

  assign mem_we_o    = we_q;
  assign mem_waddr_o = waddr_q;
  assign mem_wdata_o = th_pkg::th_pattern(waddr_q, seed_i) ^ th_pkg::th_word_t'(flip);
  assign gen_done_o  = done_q;
  assign busy_o      = we_q | done_q;  // Covers the handover cycle to the checker.

endmodule

`default_nettype wire

/* source/th_pkg.sv */
`default_nettype none

`include "th_config.svh"

package th_pkg;

  // One bus and memory data word.
  typedef logic [`TH_DATA_W-1:0] th_word_t;

  // Word address into the test memory.
  typedef logic [`TH_ADDR_W-1:0] th_addr_t;

  // Error and word counters.
  typedef logic [15:0] th_count_t;

  // Selects the status word returned on reads outside the control registers.
  typedef enum logic [1:0] {
    STAT_FLAGS      = 2'd0,  // Busy, done and pass in bits 2 to 0.
    STAT_ERRORS     = 2'd1,
    STAT_FIRST_FAIL = 2'd2,
    STAT_CHECKED    = 2'd3
  } th_stat_sel_e;

  // Reference pattern, the word address XOR the seed.
  function automatic th_word_t th_pattern(
    input th_addr_t addr,
    input th_word_t seed
  );
    th_word_t word;
    word = th_word_t'(addr) ^ seed;
    return word;
  endfunction

endpackage

`default_nettype wire

/* source/th_test_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_test_mem (
  input  wire                    wb_clk_i,
  input  wire                    we_i,
  input  wire  th_pkg::th_addr_t waddr_i,
  input  wire  th_pkg::th_word_t wdata_i,
  input  wire  th_pkg::th_addr_t raddr_i,
  output th_pkg::th_word_t       rdata_o
);

  // Stands in for the DRAM array.
  th_pkg::th_word_t mem [`TH_MEM_DEPTH];

  always_ff @(posedge wb_clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    rdata_o <= mem[raddr_i];  // One cycle of read latency.
  end

endmodule

`default_nettype wire

/* source/th_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_top (
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire                    wb_we_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire  [1:0]             wb_sel_i,
  input  wire  [31:0]            wb_adr_i,
  input  wire  th_pkg::th_word_t wb_dat_i,
  output th_pkg::th_word_t       wb_dat_o,
  output logic                   wb_ack_o
);

  logic                 run;
  logic                 inject;
  th_pkg::th_addr_t     base;
  logic [`TH_ADDR_W:0]  len;
  th_pkg::th_word_t     seed;
  th_pkg::th_addr_t     inject_addr;
  th_pkg::th_stat_sel_e status_sel;
  th_pkg::th_word_t     status;

  logic                 mem_we;
  th_pkg::th_addr_t     mem_waddr;
  th_pkg::th_word_t     mem_wdata;
  th_pkg::th_addr_t     mem_raddr;
  th_pkg::th_word_t     mem_rdata;
  logic                 gen_done;
  logic                 gen_busy;

  th_wb_regs u_regs (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .status_i      (status),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .run_o         (run),
    .inject_o      (inject),
    .base_o        (base),
    .len_o         (len),
    .seed_o        (seed),
    .inject_addr_o (inject_addr),
    .status_sel_o  (status_sel)
  );

  th_pattern_gen u_gen (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .run_i         (run),
    .inject_i      (inject),
    .base_i        (base),
    .len_i         (len),
    .seed_i        (seed),
    .inject_addr_i (inject_addr),
    .mem_we_o      (mem_we),
    .mem_waddr_o   (mem_waddr),
    .mem_wdata_o   (mem_wdata),
    .gen_done_o    (gen_done),
    .busy_o        (gen_busy)
  );

  th_test_mem u_mem (
    .wb_clk_i (wb_clk_i),
    .we_i     (mem_we),
    .waddr_i  (mem_waddr),
    .wdata_i  (mem_wdata),
    .raddr_i  (mem_raddr),
    .rdata_o  (mem_rdata)
  );

  th_checker u_chk (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .run_i        (run),
    .base_i       (base),
    .len_i        (len),
    .seed_i       (seed),
    .gen_done_i   (gen_done),
    .gen_busy_i   (gen_busy),
    .mem_rdata_i  (mem_rdata),
    .status_sel_i (status_sel),
    .mem_raddr_o  (mem_raddr),
    .status_o     (status)
  );

endmodule

`default_nettype wire

/* source/th_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_wb_regs (
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire                   wb_we_i,
  input  wire                   wb_cyc_i,
  input  wire                   wb_stb_i,
  input  wire  [1:0]            wb_sel_i,
  input  wire  [31:0]           wb_adr_i,
  input  wire  th_pkg::th_word_t wb_dat_i,
  input  wire  th_pkg::th_word_t status_i,
  output th_pkg::th_word_t      wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  run_o,
  output logic                  inject_o,
  output th_pkg::th_addr_t      base_o,
  output logic [`TH_ADDR_W:0]   len_o,
  output th_pkg::th_word_t      seed_o,
  output th_pkg::th_addr_t      inject_addr_o,
  output th_pkg::th_stat_sel_e  status_sel_o
);

  logic             req;
  logic             wr_hit;
  logic [2:0]       wr_idx;
  logic [20:0]      adr_q;
  th_pkg::th_word_t ctrl_q [5];

  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // Ack low keeps it to one beat.

  // Write decode on the live request address.
  always_comb begin
    wr_hit = 1'b1;
    wr_idx = 3'd0;
    case (wb_adr_i[21:1])
      `TH_REG_CTRL_0: wr_idx = 3'd0;
      `TH_REG_CTRL_1: wr_idx = 3'd1;
      `TH_REG_CTRL_2: wr_idx = 3'd2;
      `TH_REG_CTRL_3: wr_idx = 3'd3;
      `TH_REG_CTRL_4: wr_idx = 3'd4;
      default:        wr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      for (int i = 0; i < 5; i++) begin
        ctrl_q[i] <= '0;
      end
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i && wr_hit) begin
        if (wb_sel_i[0]) begin
          ctrl_q[wr_idx][7:0] <= wb_dat_i[7:0];
        end
        if (wb_sel_i[1]) begin
          ctrl_q[wr_idx][15:8] <= wb_dat_i[15:8];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      adr_q <= wb_adr_i[21:1];  // Steers the read mux on the ack cycle.
    end
  end

  always_comb begin
    case (adr_q)
      `TH_REG_CTRL_0: wb_dat_o = ctrl_q[0];
      `TH_REG_CTRL_1: wb_dat_o = ctrl_q[1];
      `TH_REG_CTRL_2: wb_dat_o = ctrl_q[2];
      `TH_REG_CTRL_3: wb_dat_o = ctrl_q[3];
      `TH_REG_CTRL_4: wb_dat_o = ctrl_q[4];
      default:        wb_dat_o = status_i;
    endcase
  end

  assign status_sel_o = th_pkg::th_stat_sel_e'(adr_q[1:0]);

  assign run_o         = ctrl_q[0][0];
  assign inject_o      = ctrl_q[0][1];
  assign base_o        = ctrl_q[1][`TH_ADDR_W-1:0];
  assign len_o         = ctrl_q[2][`TH_ADDR_W:0];
  assign seed_o        = ctrl_q[3];
  assign inject_addr_o = ctrl_q[4][`TH_ADDR_W-1:0];

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/th_pkg.sv
source/th_wb_regs.sv
source/th_pattern_gen.sv
source/th_test_mem.sv
source/th_checker.sv
source/th_top.sv
verif/th_tb.sv

/* verif/th_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "th_config.svh"

module th_tb;

  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 2000;
  localparam int NUM_RUNS   = 12;
  localparam int NUM_FIXED  = 6;

  typedef struct packed {
    logic [`TH_ADDR_W-1:0] base;
    logic [`TH_ADDR_W:0]   len;
    logic [`TH_DATA_W-1:0] seed;
    logic                  inject;
    logic [`TH_ADDR_W-1:0] inject_addr;
    logic [15:0]           exp_errors;
    logic [`TH_ADDR_W-1:0] exp_first;
  } run_t;

  logic                  wb_clk_i = 1'b0;
  logic                  wb_rst_i;
  logic                  wb_we_i;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic [1:0]            wb_sel_i;
  logic [31:0]           wb_adr_i;
  logic [`TH_DATA_W-1:0] wb_dat_i;
  logic [`TH_DATA_W-1:0] wb_dat_o;
  logic                  wb_ack_o;

  run_t        runs [NUM_RUNS];
  string       run_name [NUM_RUNS];
  logic [31:0] rng_state;

  th_top u_dut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // The bus carries byte addresses, the register map uses word addresses.
  function automatic logic [31:0] word_adr(input logic [20:0] word);
    return {10'd0, word, 1'b0};
  endfunction

  function automatic logic [31:0] stat_adr(input logic [1:0] sel);
    return word_adr(`TH_STAT_BASE + 21'(sel));
  endfunction

  function automatic logic [15:0] merge_lanes(
    input logic [15:0] old_data,
    input logic [15:0] wdata,
    input logic [1:0]  sel
  );
    logic [15:0] merged;
    merged = old_data;
    if (sel[0]) begin
      merged[7:0] = wdata[7:0];
    end
    if (sel[1]) begin
      merged[15:8] = wdata[15:8];
    end
    return merged;
  endfunction

  // Writes the range as the producer would, then reads it back against the clean pattern.
  task automatic model_run(
    input  run_t        r,
    output logic [15:0] errors,
    output logic [7:0]  first_fail
  );
    logic [7:0]  addr;
    logic [15:0] wanted;
    logic [15:0] written;
    errors = '0;
    first_fail = '0;
    for (int i = 0; i < int'(r.len); i++) begin
      addr = r.base + 8'(i);
      wanted = {8'h00, addr} ^ r.seed;
      written = wanted;
      if (r.inject && addr == r.inject_addr) begin
        written[0] = ~written[0];
      end
      if (written != wanted) begin
        if (errors == 16'd0) begin
          first_fail = addr;
        end
        errors = errors + 16'd1;
      end
    end
  endtask

  task automatic check_value(
    input string       name,
    input logic [15:0] expected,
    input logic [15:0] actual
  );
    if (actual !== expected) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("tests failed");
    $fatal(1, "stopped on a timeout");
  endtask

  task automatic bus_cycle(
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [15:0] wdata,
    input  logic [1:0]  sel,
    output logic [15:0] rdata
  );
    int waited;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    waited = 0;
    @(negedge wb_clk_i);
    while (!wb_ack_o) begin
      waited++;
      if (waited >= ACK_LIMIT) begin
        report_timeout($sformatf("no ack from the DUT for address %h", adr));
      end
      @(negedge wb_clk_i);
    end
    rdata = wb_dat_o;  // Ack and read data are settled by the falling edge.
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [15:0] data,
                           input logic [1:0] sel);
    logic [15:0] unused;
    bus_cycle(1'b1, adr, data, sel, unused);
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [15:0] data);
    bus_cycle(1'b0, adr, 16'h0000, 2'b11, data);
  endtask

  task automatic set_row(
    input int          idx,
    input string       name,
    input logic [7:0]  base,
    input logic [8:0]  len,
    input logic [15:0] seed,
    input logic        inject,
    input logic [7:0]  inject_addr,
    input logic [15:0] exp_errors,
    input logic [7:0]  exp_first
  );
    runs[idx] = '{base, len, seed, inject, inject_addr, exp_errors, exp_first};
    run_name[idx] = name;
  endtask

  task automatic load_table();
    run_t        r;
    logic [15:0] errs;
    logic [7:0]  ff;
    //      idx  name                   base     len     seed      inj   iaddr    errors  first
    set_row(0, "clean",               8'd10,  9'd32,  16'hA5C3, 1'b0, 8'd0,   16'd0, 8'd0);
    set_row(1, "inject_in_range",     8'd40,  9'd20,  16'h1234, 1'b1, 8'd45,  16'd1, 8'd45);
    set_row(2, "inject_outside_wrap", 8'd250, 9'd12,  16'hBEEF, 1'b1, 8'd100, 16'd0, 8'd0);
    set_row(3, "zero_length",         8'd7,   9'd0,   16'h0F0F, 1'b1, 8'd7,   16'd0, 8'd0);
    set_row(4, "restart_fail",        8'd0,   9'd16,  16'h5555, 1'b1, 8'd9,   16'd1, 8'd9);
    set_row(5, "restart_clean",       8'd0,   9'd16,  16'h5555, 1'b0, 8'd9,   16'd0, 8'd0);
    for (int i = NUM_FIXED; i < NUM_RUNS; i++) begin
      rng_state = lcg_next(rng_state);
      r.base = rng_state[31:24];
      r.len = 9'(rng_state[23:8] % 16'd300);
      rng_state = lcg_next(rng_state);
      r.seed = rng_state[31:16];
      r.inject = rng_state[15];
      r.inject_addr = r.base + 8'(rng_state[14:5] % (10'(r.len) + 10'd1));
      model_run(r, errs, ff);
      r.exp_errors = errs;
      r.exp_first = ff;
      runs[i] = r;
      run_name[i] = $sformatf("random_%0d", i);
    end
  endtask

  task automatic check_registers();
    logic [15:0] first_data [5];
    logic [15:0] second_data [5];
    logic [1:0]  second_sel [5];
    logic [15:0] actual;
    first_data  = '{16'hC3A4, 16'h1122, 16'h3344, 16'h5566, 16'h7788};
    second_data = '{16'h0F0E, 16'hAB00, 16'h00CD, 16'hEF12, 16'h9999};
    second_sel  = '{2'b01, 2'b10, 2'b01, 2'b10, 2'b00};
    for (int i = 0; i < 5; i++) begin
      bus_write(word_adr(21'(i)), first_data[i], 2'b11);
    end
    for (int i = 0; i < 5; i++) begin
      bus_write(word_adr(21'(i)), second_data[i], second_sel[i]);
    end
    bus_write(word_adr(21'd5), 16'hFFFF, 2'b11);  // Not a control register.
    for (int i = 0; i < 5; i++) begin
      bus_read(word_adr(21'(i)), actual);
      check_value($sformatf("ctrl_%0d readback", i),
                  merge_lanes(first_data[i], second_data[i], second_sel[i]), actual);
    end
    // With run never set, no run may have started.
    bus_read(stat_adr(th_pkg::STAT_FLAGS), actual);
    check_value("flags idle after register writes", 16'd0, actual);
  endtask

  task automatic run_one(input int idx);
    run_t        r;
    string       name;
    logic [15:0] flags;
    logic [15:0] value;
    int          polls;
    r = runs[idx];
    name = run_name[idx];
    bus_write(word_adr(`TH_REG_CTRL_0), 16'h0000, 2'b11);
    bus_write(word_adr(`TH_REG_CTRL_1), {8'h00, r.base}, 2'b11);
    bus_write(word_adr(`TH_REG_CTRL_2), {7'd0, r.len}, 2'b11);
    bus_write(word_adr(`TH_REG_CTRL_3), r.seed, 2'b11);
    bus_write(word_adr(`TH_REG_CTRL_4), {8'h00, r.inject_addr}, 2'b11);
    bus_write(word_adr(`TH_REG_CTRL_0), {14'd0, r.inject, 1'b1}, 2'b11);
    // No compare can land this early, so a nonzero count is left over.
    bus_read(stat_adr(th_pkg::STAT_ERRORS), value);
    check_value({name, " errors cleared"}, 16'd0, value);
    flags = '0;
    polls = 0;
    while (!flags[1]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        report_timeout($sformatf("run %s never reached done", name));
      end
      bus_read(stat_adr(th_pkg::STAT_FLAGS), flags);
    end
    check_value({name, " flags"}, {13'd0, 1'b0, 1'b1, r.exp_errors == 16'd0}, flags);
    bus_read(stat_adr(th_pkg::STAT_ERRORS), value);
    check_value({name, " errors"}, r.exp_errors, value);
    bus_read(stat_adr(th_pkg::STAT_FIRST_FAIL), value);
    check_value({name, " first fail"}, {8'h00, r.exp_first}, value);
    bus_read(stat_adr(th_pkg::STAT_CHECKED), value);
    check_value({name, " checked"}, {7'd0, r.len}, value);
  endtask

  initial begin
    wb_rst_i  = 1'b1;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_sel_i  = 2'b00;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    rng_state = 32'h358b_2c79;
    load_table();
    repeat (8) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    check_registers();
    for (int i = 0; i < NUM_RUNS; i++) begin
      run_one(i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
